// File: acc_cfg_pkg.sv
`default_nettype none

package acc_cfg_pkg;

  // accumulator array geometry.
  localparam int copies = 1;
  localparam int groups = 2;
  localparam int units  = 2;

  localparam int members   = 4;                   // columns per input beat.
  localparam int dw_factor = 2;                   // first stage ratio.
  localparam int sub_cores = members / dw_factor; // second stage ratio.

  localparam int word_width = 16;
  localparam int user_width = 4;

  // one member column across every copy, group and unit.
  localparam int col_bits = copies * groups * units * word_width;

  // keep bit plus user tag of one column.
  localparam int col_side_bits = 1 + user_width;

  typedef logic [word_width-1:0] acc_word_t;
  typedef logic [user_width-1:0] acc_user_t;

endpackage

`default_nettype wire

// File: acc_stream_pkg.sv
`default_nettype none

package acc_stream_pkg;

  // full accumulator beat, every member column.
  typedef struct packed {
    acc_cfg_pkg::acc_word_t [acc_cfg_pkg::copies-1:0]
                            [acc_cfg_pkg::groups-1:0]
                            [acc_cfg_pkg::units-1:0]
                            [acc_cfg_pkg::members-1:0] data;
    logic                   [acc_cfg_pkg::members-1:0] keep;
    acc_cfg_pkg::acc_user_t [acc_cfg_pkg::members-1:0] user;
    logic                                              last;
  } bank_in_t;

  // after stage1, one column per sub-core.
  typedef struct packed {
    acc_cfg_pkg::acc_word_t [acc_cfg_pkg::copies-1:0]
                            [acc_cfg_pkg::groups-1:0]
                            [acc_cfg_pkg::units-1:0]
                            [acc_cfg_pkg::sub_cores-1:0] data;
    logic                   [acc_cfg_pkg::sub_cores-1:0] keep;
    acc_cfg_pkg::acc_user_t [acc_cfg_pkg::sub_cores-1:0] user;
    logic                                                last;
  } bank_mid_t;

  // a single member column.
  typedef struct packed {
    acc_cfg_pkg::acc_word_t [acc_cfg_pkg::copies-1:0]
                            [acc_cfg_pkg::groups-1:0]
                            [acc_cfg_pkg::units-1:0] data;
    logic                                            keep;
    acc_cfg_pkg::acc_user_t                          user;
    logic                                            last;
  } bank_out_t;

endpackage

`default_nettype wire

// File: acc_width_stage.sv
`timescale 1ns/1ps
`default_nettype none

module acc_width_stage #(
  parameter int ratio      = 2,
  parameter int slice_bits = 16,
  parameter int side_bits  = 1
) (
  input  wire logic                        aclk,
  input  wire logic                        rst_n,

  input  wire logic                        in_valid,
  output logic                             in_ready,
  input  wire logic [ratio*slice_bits-1:0] in_data,
  input  wire logic [ratio*side_bits-1:0]  in_side,
  input  wire logic                        in_last,

  output logic                             out_valid,
  input  wire logic                        out_ready,
  output logic      [slice_bits-1:0]       out_data,
  output logic      [side_bits-1:0]        out_side,
  output logic                             out_last
);

  localparam int cnt_w = $clog2(ratio);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(ratio - 1);

  logic [ratio-1:0][slice_bits-1:0] data_q;
  logic [ratio-1:0][side_bits-1:0]  side_q;
  logic                             last_q;

  logic             full_q;
  logic [cnt_w-1:0] cnt_q;
  logic             final_slice;
  logic             in_fire;
  logic             out_fire;

  assign final_slice = (cnt_q == last_cnt);
  assign in_fire     = in_valid && in_ready;
  assign out_fire    = full_q && out_ready;

  // free, or the last slice leaves this cycle.
  assign in_ready = !full_q || (out_ready && final_slice);

  assign out_valid = full_q;
  assign out_data  = data_q[cnt_q];
  assign out_side  = side_q[cnt_q];
  assign out_last  = last_q && final_slice;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
      cnt_q  <= '0;
    end else if (in_fire) begin
      // direct reload, no bubble between beats.
      full_q <= 1'b1;
      cnt_q  <= '0;
    end else if (out_fire) begin
      if (final_slice) begin
        full_q <= 1'b0;
        cnt_q  <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (in_fire) begin
      data_q <= in_data;
      side_q <= in_side;
      last_q <= in_last;
    end
  end

endmodule

`default_nettype wire

// File: acc_out_slice.sv
`timescale 1ns/1ps
`default_nettype none

module acc_out_slice (
  input  wire logic                      aclk,
  input  wire logic                      rst_n,

  input  wire logic                      in_valid,
  output logic                           in_ready,
  input  wire acc_stream_pkg::bank_out_t in_beat,

  output logic                           out_valid,
  output acc_stream_pkg::bank_out_t      out_beat,
  input  wire logic                      out_ready
);

  typedef enum logic [1:0] {
    empty,
    one,
    two
  } occ_e;

  occ_e state_q;
  occ_e state_d;

  acc_stream_pkg::bank_out_t out_q;
  acc_stream_pkg::bank_out_t skid_q;

  logic store;
  logic pop;

  // cleared columns are taken but never stored.
  assign store = in_valid && in_ready && in_beat.keep;
  assign pop   = out_valid && out_ready;

  assign out_valid = (state_q != empty);
  assign out_beat  = out_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      empty: if (store) state_d = one;
      one: begin
        if (store && !pop) state_d = two;
        else if (!store && pop) state_d = empty;
      end
      two: if (pop) state_d = one;
      default: state_d = empty;
    endcase
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= empty;
      in_ready <= 1'b1;  // both entries free.
    end else begin
      state_q  <= state_d;
      in_ready <= (state_d != two);
    end
  end

  always_ff @(posedge aclk) begin
    if (state_q == two) begin
      if (pop) out_q <= skid_q;  // skid moves up.
    end else if (store && (state_q == empty || pop)) begin
      out_q <= in_beat;
    end
    if (store && state_q == one && !pop) skid_q <= in_beat;
  end

endmodule

`default_nettype wire

// File: acc_dw_bank.sv
`timescale 1ns/1ps
`default_nettype none

module acc_dw_bank (
  input  wire logic                      aclk,
  input  wire logic                      rst_n,

  input  wire logic                      s_valid,
  output logic                           s_ready,
  input  wire acc_stream_pkg::bank_in_t  s_beat,

  output logic                           m_valid,
  input  wire logic                      m_ready,
  output acc_stream_pkg::bank_out_t      m_beat
);

  localparam int cp = acc_cfg_pkg::copies;
  localparam int gr = acc_cfg_pkg::groups;
  localparam int un = acc_cfg_pkg::units;
  localparam int dw = acc_cfg_pkg::dw_factor;
  localparam int sc = acc_cfg_pkg::sub_cores;

  // stage1 input, slice k first.
  acc_cfg_pkg::acc_word_t [dw-1:0][cp-1:0][gr-1:0][un-1:0][sc-1:0] s1_in_data;
  logic                   [dw-1:0][sc-1:0]                         s1_in_keep;
  acc_cfg_pkg::acc_user_t [dw-1:0][sc-1:0]                         s1_in_user;
  logic [dw-1:0][sc*acc_cfg_pkg::col_side_bits-1:0]                s1_in_side;
  logic [sc*acc_cfg_pkg::col_bits-1:0]                             s1_out_data;
  logic [sc*acc_cfg_pkg::col_side_bits-1:0]                        s1_out_side;

  // stage2 input, one sub-core per slice.
  acc_cfg_pkg::acc_word_t [sc-1:0][cp-1:0][gr-1:0][un-1:0]         s2_in_data;
  logic [sc-1:0][acc_cfg_pkg::col_side_bits-1:0]                   s2_in_side;
  logic [acc_cfg_pkg::col_bits-1:0]                                s2_out_data;
  logic [acc_cfg_pkg::col_side_bits-1:0]                           s2_out_side;

  acc_stream_pkg::bank_mid_t mid_beat;
  acc_stream_pkg::bank_out_t col_beat;
  logic                      mid_valid;
  logic                      mid_ready;
  logic                      col_valid;
  logic                      col_ready;

  for (genvar k = 0; k < dw; k++) begin : g_k
    for (genvar s = 0; s < sc; s++) begin : g_s
      for (genvar c = 0; c < cp; c++) begin : g_c
        for (genvar g = 0; g < gr; g++) begin : g_g
          for (genvar u = 0; u < un; u++) begin : g_u
            assign s1_in_data[k][c][g][u][s] = s_beat.data[c][g][u][s*dw+k];
          end
        end
      end
      assign s1_in_keep[k][s] = s_beat.keep[s*dw+k];
      assign s1_in_user[k][s] = s_beat.user[s*dw+k];
    end
    assign s1_in_side[k] = {s1_in_keep[k], s1_in_user[k]};
  end

  acc_width_stage #(
    .ratio      (dw),
    .slice_bits (sc * acc_cfg_pkg::col_bits),
    .side_bits  (sc * acc_cfg_pkg::col_side_bits)
  ) stage1 (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .in_data   (s1_in_data),
    .in_side   (s1_in_side),
    .in_last   (s_beat.last),
    .out_valid (mid_valid),
    .out_ready (mid_ready),
    .out_data  (s1_out_data),
    .out_side  (s1_out_side),
    .out_last  (mid_beat.last)
  );

  assign mid_beat.data                  = s1_out_data;
  assign {mid_beat.keep, mid_beat.user} = s1_out_side;

  for (genvar s = 0; s < sc; s++) begin : g_sub
    for (genvar c = 0; c < cp; c++) begin : g_c
      for (genvar g = 0; g < gr; g++) begin : g_g
        for (genvar u = 0; u < un; u++) begin : g_u
          assign s2_in_data[s][c][g][u] = mid_beat.data[c][g][u][s];
        end
      end
    end
    assign s2_in_side[s] = {mid_beat.keep[s], mid_beat.user[s]};
  end

  acc_width_stage #(
    .ratio      (sc),
    .slice_bits (acc_cfg_pkg::col_bits),
    .side_bits  (acc_cfg_pkg::col_side_bits)
  ) stage2 (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (mid_valid),
    .in_ready  (mid_ready),
    .in_data   (s2_in_data),
    .in_side   (s2_in_side),
    .in_last   (mid_beat.last),
    .out_valid (col_valid),
    .out_ready (col_ready),
    .out_data  (s2_out_data),
    .out_side  (s2_out_side),
    .out_last  (col_beat.last)
  );

  assign col_beat.data                  = s2_out_data;
  assign {col_beat.keep, col_beat.user} = s2_out_side;

  acc_out_slice slice0 (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (col_valid),
    .in_ready  (col_ready),
    .in_beat   (col_beat),
    .out_valid (m_valid),
    .out_beat  (m_beat),
    .out_ready (m_ready)
  );

endmodule

`default_nettype wire

// File: acc_dw_bank_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module acc_dw_bank_assertions (
  input wire logic                      aclk,
  input wire logic                      rst_n,
  input wire logic                      s_valid,
  input wire logic                      s_ready,
  input wire acc_stream_pkg::bank_in_t  s_beat,
  input wire logic                      m_valid,
  input wire logic                      m_ready,
  input wire acc_stream_pkg::bank_out_t m_beat
);

  int fail_count = 0;  // read by the testbench.

  // stalled output keeps valid and payload.
  m_valid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid)
  else begin
    fail_count++;
    $error("m_valid dropped before its handshake");
  end

  m_beat_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> $stable(m_beat))
  else begin
    fail_count++;
    $error("m_beat changed while stalled");
  end

  s_beat_hold: assert property (@(posedge aclk) disable iff (!rst_n)
    s_valid && !s_ready |=> s_valid && $stable(s_beat))
  else begin
    fail_count++;
    $error("s_valid or s_beat changed while stalled");
  end

  rst_no_valid: assert property (@(posedge aclk) !rst_n |-> !m_valid)
  else begin
    fail_count++;
    $error("m_valid high during reset");
  end

endmodule

`default_nettype wire

// File: tb_acc_dw_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_acc_dw_bank;

  localparam int cp = acc_cfg_pkg::copies;
  localparam int gr = acc_cfg_pkg::groups;
  localparam int un = acc_cfg_pkg::units;
  localparam int dw = acc_cfg_pkg::dw_factor;
  localparam int sc = acc_cfg_pkg::sub_cores;
  localparam int n_rows = 13;
  localparam int n_burst = 6;
  localparam int timeout_cycles = 400;

  // one stimulus row.
  typedef struct packed {
    logic [3:0] keep;
    logic       last;
    logic       fixed;  // 1 selects the fixed data pattern.
    logic [3:0] gap;
    logic [6:0] duty;   // m_ready high percentage.
  } row_t;

  logic                      aclk;
  logic                      rst_n;
  logic                      s_valid;
  logic                      s_ready;
  acc_stream_pkg::bank_in_t  s_beat;
  logic                      m_valid;
  logic                      m_ready;
  acc_stream_pkg::bank_out_t m_beat;

  row_t rows [n_rows];
  acc_stream_pkg::bank_out_t exp_q [$];
  int cur_duty = 100;

  acc_dw_bank dut0 (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_beat  (s_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_beat  (m_beat)
  );

  bind acc_dw_bank acc_dw_bank_assertions checks0 (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_beat  (s_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_beat  (m_beat)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  task automatic abort_run(input string why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  function automatic acc_stream_pkg::bank_in_t make_beat(input row_t row);
    acc_stream_pkg::bank_in_t b;
    b.keep = row.keep;
    b.last = row.last;
    for (int m = 0; m < acc_cfg_pkg::members; m++) begin
      b.user[m] = row.fixed ? acc_cfg_pkg::acc_user_t'(m + 8) : acc_cfg_pkg::acc_user_t'($urandom);
      for (int c = 0; c < cp; c++) begin
        for (int g = 0; g < gr; g++) begin
          for (int u = 0; u < un; u++) begin
            b.data[c][g][u][m] = row.fixed ? {4'hc, 4'(m), 4'(c), 2'(g), 2'(u)}
                                           : 16'($urandom);
          end
        end
      end
    end
    return b;
  endfunction

  // columns leave as s*dw+k, k outer, cleared keep removed.
  function automatic void push_expected(input acc_stream_pkg::bank_in_t b);
    acc_stream_pkg::bank_out_t e;
    int col;
    for (int k = 0; k < dw; k++) begin
      for (int s = 0; s < sc; s++) begin
        col = s * dw + k;
        if (b.keep[col]) begin
          for (int c = 0; c < cp; c++) begin
            for (int g = 0; g < gr; g++) begin
              for (int u = 0; u < un; u++) begin
                e.data[c][g][u] = b.data[c][g][u][col];
              end
            end
          end
          e.keep = 1'b1;
          e.user = b.user[col];
          e.last = b.last && (k == dw - 1) && (s == sc - 1);
          exp_q.push_back(e);
        end
      end
    end
  endfunction

  // called 2 ns after a rising edge.
  task automatic send_beat(input acc_stream_pkg::bank_in_t b, input int gap);
    int waited;
    waited = 0;
    s_beat  = b;
    s_valid = 1'b1;
    @(negedge aclk);
    while (!s_ready) begin
      waited++;
      if (waited > timeout_cycles) abort_run("s_ready stayed low too long");
      @(negedge aclk);
    end
    @(posedge aclk);
    #2;
    s_valid = 1'b0;
    repeat (gap) begin
      @(posedge aclk);
      #2;
    end
  endtask

  task automatic drain_queue();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > timeout_cycles) abort_run("expected columns never came out");
      @(posedge aclk);
    end
  endtask

  task automatic check_throughput(input int n);
    int waited;
    int hs;
    waited = 0;
    hs = 0;
    @(negedge aclk);
    while (!m_valid) begin
      waited++;
      if (waited > timeout_cycles) abort_run("no output appeared during the burst");
      @(negedge aclk);
    end
    repeat (4 * n) begin
      if (m_valid && m_ready) hs++;
      @(negedge aclk);
    end
    assert (hs == 4 * n)
    else begin
      $display("ERR m_valid handshakes expected %h got %h", 4 * n, hs);
      abort_run("burst throughput below one column per cycle");
    end
  endtask

  initial begin
    int duty_now;
    forever begin
      @(posedge aclk);
      duty_now = cur_duty;  // taken at the edge, new duty applies a cycle later.
      #2;
      m_ready = (duty_now >= 100) || (($urandom % 100) < duty_now);
    end
  end

  // outputs sampled at the falling edge.
  initial begin : monitor
    acc_stream_pkg::bank_out_t want;
    forever begin
      @(negedge aclk);
      assert (dut0.checks0.fail_count == 0)
      else abort_run("a bound protocol assertion failed");
      if (rst_n && m_valid && m_ready) begin
        assert (exp_q.size() > 0)
        else abort_run("output column appeared with none expected");
        want = exp_q.pop_front();
        assert (m_beat.data == want.data)
        else begin
          $display("ERR m_beat.data expected %h got %h", want.data, m_beat.data);
          abort_run("column data mismatch");
        end
        assert (m_beat.user == want.user)
        else begin
          $display("ERR m_beat.user expected %h got %h", want.user, m_beat.user);
          abort_run("column user mismatch");
        end
        assert (m_beat.last == want.last)
        else begin
          $display("ERR m_beat.last expected %h got %h", want.last, m_beat.last);
          abort_run("column last mismatch");
        end
        assert (m_beat.keep == want.keep)
        else begin
          $display("ERR m_beat.keep expected %h got %h", want.keep, m_beat.keep);
          abort_run("column keep mismatch");
        end
      end
    end
  end

  initial begin
    row_t burst_row;
    acc_stream_pkg::bank_in_t b;
    void'($urandom(32'hfde2c7bb));
    rst_n   = 1'b0;
    s_valid = 1'b0;
    s_beat  = '0;
    m_ready = 1'b0;
    rows[0]  = '{4'hf, 1'b1, 1'b1, 4'd0, 7'd100};
    rows[1]  = '{4'hf, 1'b0, 1'b0, 4'd0, 7'd100};
    rows[2]  = '{4'hf, 1'b1, 1'b0, 4'd0, 7'd100};
    rows[3]  = '{4'h5, 1'b0, 1'b0, 4'd1, 7'd100};
    rows[4]  = '{4'ha, 1'b1, 1'b0, 4'd0, 7'd100};
    rows[5]  = '{4'h0, 1'b0, 1'b0, 4'd2, 7'd100};  // every column dropped.
    rows[6]  = '{4'h9, 1'b1, 1'b0, 4'd0, 7'd100};
    rows[7]  = '{4'hf, 1'b1, 1'b0, 4'd0, 7'd50};
    rows[8]  = '{4'h6, 1'b0, 1'b0, 4'd0, 7'd30};
    rows[9]  = '{4'hb, 1'b1, 1'b0, 4'd3, 7'd60};
    rows[10] = '{4'h8, 1'b1, 1'b1, 4'd0, 7'd25};
    rows[11] = '{4'hf, 1'b0, 1'b0, 4'd0, 7'd70};
    rows[12] = '{4'hc, 1'b1, 1'b0, 4'd1, 7'd40};
    burst_row = '{4'hf, 1'b1, 1'b0, 4'd0, 7'd100};

    repeat (16) @(posedge aclk);
    #2;
    rst_n = 1'b1;
    @(posedge aclk);
    #2;

    for (int r = 0; r < n_rows; r++) begin
      cur_duty = rows[r].duty;
      b = make_beat(rows[r]);
      push_expected(b);
      send_beat(b, rows[r].gap);
    end
    drain_queue();

    // back-to-back burst, one column per cycle.
    #2;
    cur_duty = 100;
    @(posedge aclk);
    #2;
    @(posedge aclk);
    #2;
    fork
      begin
        for (int i = 0; i < n_burst; i++) begin
          b = make_beat(burst_row);
          push_expected(b);
          send_beat(b, 0);
        end
      end
      check_throughput(n_burst);
    join
    drain_queue();
    @(posedge aclk);
    #2;

    if (dut0.checks0.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      abort_run("a bound protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

// File: src.f
acc_cfg_pkg.sv
acc_stream_pkg.sv
acc_width_stage.sv
acc_out_slice.sv
acc_dw_bank.sv
acc_dw_bank_assertions.sv
tb_acc_dw_bank.sv

// File: Bender.yml
package:
  name: acc_dw_bank

sources:
  - files:
      - acc_cfg_pkg.sv
      - acc_stream_pkg.sv
      - acc_width_stage.sv
      - acc_out_slice.sv
      - acc_dw_bank.sv
  - target: simulation
    files:
      - acc_dw_bank_assertions.sv
      - tb_acc_dw_bank.sv
